/* rtl/rv_isa_pkg.sv */
/* RV32 base encodings only. Compressed instructions are not decoded here.
   FENCE/FENCE.I masks ignore rd, rs1, imm and the fence ordering bits */
package rv_isa_pkg;

  // basic ISA vectors
  typedef logic [31:0] insn_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // MISC-MEM opcode, funct3 = 001
  localparam insn_t FENCEI_IDATA = 32'b000000000000_00000_001_00000_0001111;
  localparam insn_t FENCEI_IMASK = 32'b000000000000_00000_111_00000_1111111;

  // MISC-MEM opcode, funct3 = 000
  localparam insn_t FENCE_IDATA  = 32'b000000000000_00000_000_00000_0001111;
  localparam insn_t FENCE_IMASK  = 32'b000000000000_00000_111_00000_1111111;

endpackage

/* rtl/fencei_pkg.sv */
/* Cache geometry is fixed at 8 direct-mapped lines of one word each.
   Outstanding data bus writes are limited by OUTST_W */
package fencei_pkg;

  localparam int unsigned NUM_LINES = 8;
  localparam int unsigned INDEX_W   = 3;
  localparam int unsigned TAG_W     = 32 - INDEX_W - 2;
  // counter width for outstanding bus writes
  localparam int unsigned OUTST_W   = 3;

  typedef logic [INDEX_W-1:0] line_idx_t;
  typedef logic [TAG_W-1:0]   line_tag_t;

  typedef enum logic {WBUF_EMPTY, WBUF_FULL} wbuf_state_e;

  typedef enum logic [1:0] {IDLE, DRAIN, FLUSH, REDIRECT} fencei_state_e;

  // one retiring instruction from writeback
  typedef struct packed {
    logic              valid;
    rv_isa_pkg::addr_t pc;
    rv_isa_pkg::insn_t insn;
  } retire_t;

  typedef struct packed {
    logic              valid;
    rv_isa_pkg::addr_t addr;
    rv_isa_pkg::word_t data;
    logic              bufferable;
  } store_t;

  // data bus write
  typedef struct packed {
    logic              valid;
    rv_isa_pkg::addr_t addr;
    rv_isa_pkg::word_t data;
  } bus_req_t;

  typedef struct packed {
    logic              valid;
    rv_isa_pkg::addr_t pc;
  } redirect_t;

  typedef struct packed {
    logic              valid;
    rv_isa_pkg::addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    logic              valid;
    logic              hit;
    rv_isa_pkg::insn_t insn;
  } fetch_rsp_t;

  typedef struct packed {
    logic              valid;
    rv_isa_pkg::addr_t addr;
    rv_isa_pkg::insn_t insn;
  } refill_t;

endpackage

/* rtl/fencei_ctrl.sv */
/* Retire strobes are only accepted in IDLE; the environment must hold them off
   while busy_o is high. Flush request stays high until the one-cycle ack */
module fencei_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  fencei_pkg::retire_t   retire_i,
  input  logic                  drained_i,
  input  logic                  flush_ack_i,
  output logic                  drain_req_o,
  output logic                  flush_req_o,
  output logic                  busy_o,
  output fencei_pkg::redirect_t redirect_o
);
  import rv_isa_pkg::*;
  import fencei_pkg::*;

  fencei_state_e state_q;
  fencei_state_e state_d;
  logic          is_fence;
  logic          is_fencei;
  logic          accept;
  logic          fencei_q;
  addr_t         pc_q;
  addr_t         pc_next;

  // decode of the retiring word, rd/rs1/imm ignored
  assign is_fencei = (retire_i.insn & FENCEI_IMASK) == FENCEI_IDATA;
  assign is_fence  = (retire_i.insn & FENCE_IMASK) == FENCE_IDATA;

  assign accept = (state_q == IDLE) && retire_i.valid && (is_fence || is_fencei);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (accept) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        // plain fence ends here once the data side is quiet
        if (drained_i) begin
          state_d = fencei_q ? FLUSH : IDLE;
        end
      end
      FLUSH: begin
        if (flush_ack_i) begin
          state_d = REDIRECT;
        end
      end
      REDIRECT: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      fencei_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        fencei_q <= is_fencei;
      end
    end
  end

  // retire pc, only read after a fence.i was accepted
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pc_q <= retire_i.pc;
    end
  end

  // next sequential pc, word aligned
  assign pc_next = {pc_q[31:2], 2'b00} + addr_t'(4);

  assign busy_o      = (state_q != IDLE);
  assign drain_req_o = (state_q == DRAIN);
  assign flush_req_o = (state_q == FLUSH);

  assign redirect_o.valid = (state_q == REDIRECT);
  assign redirect_o.pc    = pc_next;

endmodule

/* rtl/lsu_write_buffer.sv */
/* Bus must accept each write in the cycle it is issued. At most
   2**OUTST_W-1 writes may await a response at once */
module lsu_write_buffer (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  fencei_pkg::store_t   store_i,
  input  logic                 drain_req_i,
  input  logic                 data_rvalid_i,
  output fencei_pkg::bus_req_t data_req_o,
  output logic                 drained_o
);
  import rv_isa_pkg::*;
  import fencei_pkg::*;

  wbuf_state_e        state_q;
  wbuf_state_e        state_d;
  logic               full;
  logic               issue_ent;
  logic               issue_new;
  logic               load_ent;
  addr_t              ent_addr_q;
  word_t              ent_data_q;
  logic               ent_buf_q;
  logic               req_valid_q;
  addr_t              req_addr_q;
  word_t              req_data_q;
  logic [OUTST_W-1:0] outst_q;

  assign full = (state_q == WBUF_FULL);

  // buffered entry leaves first, keeps store order
  assign issue_ent = full && (store_i.valid || drain_req_i || !ent_buf_q);
  // non-bufferable store with empty buffer goes straight out
  assign issue_new = !full && store_i.valid && !store_i.bufferable;
  assign load_ent  = store_i.valid && (full || store_i.bufferable);

  always_comb begin
    state_d = state_q;
    if (load_ent) begin
      state_d = WBUF_FULL;
    end else if (issue_ent) begin
      state_d = WBUF_EMPTY;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= WBUF_EMPTY;
      req_valid_q <= 1'b0;
      outst_q     <= '0;
    end else begin
      state_q     <= state_d;
      req_valid_q <= issue_ent || issue_new;
      outst_q     <= outst_q + OUTST_W'(issue_ent || issue_new) - OUTST_W'(data_rvalid_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_ent) begin
      ent_addr_q <= store_i.addr;
      ent_data_q <= store_i.data;
      ent_buf_q  <= store_i.bufferable;
    end
    req_addr_q <= issue_ent ? ent_addr_q : store_i.addr;
    req_data_q <= issue_ent ? ent_data_q : store_i.data;
  end

  assign data_req_o = '{valid: req_valid_q, addr: req_addr_q, data: req_data_q};

  assign drained_o = !full && (outst_q == '0) && !store_i.valid;

endmodule

/* rtl/icache_flush_seq.sv */
/* Flush takes NUM_LINES+1 cycles from request to ack.
   Refills are dropped while a flush request is pending */
module icache_flush_seq (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_req_i,
  input  fencei_pkg::refill_t             refill_i,
  output logic [fencei_pkg::NUM_LINES-1:0] inv_o,
  output logic [fencei_pkg::NUM_LINES-1:0] fill_o,
  output fencei_pkg::line_tag_t           fill_tag_o,
  output rv_isa_pkg::insn_t               fill_insn_o,
  output logic                            flush_ack_o
);
  import fencei_pkg::*;

  logic      active_q;
  line_idx_t idx_q;
  line_idx_t fill_idx;

  // walk starts the cycle after the request is first seen
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      idx_q    <= '0;
    end else if (active_q) begin
      active_q <= !flush_ack_o;
      idx_q    <= idx_q + line_idx_t'(1);
    end else if (flush_req_i) begin
      active_q <= 1'b1;
      idx_q    <= '0;
    end
  end

  assign flush_ack_o = active_q && (idx_q == line_idx_t'(NUM_LINES - 1));

  assign fill_idx    = refill_i.addr[INDEX_W+1:2];
  assign fill_tag_o  = refill_i.addr[31:INDEX_W+2];
  assign fill_insn_o = refill_i.insn;

  always_comb begin
    inv_o  = '0;
    fill_o = '0;
    if (active_q) begin
      inv_o[idx_q] = 1'b1;
    end
    if (refill_i.valid && !flush_req_i) begin
      fill_o[fill_idx] = 1'b1;
    end
  end

endmodule

/* rtl/icache_line.sv */
/* One direct-mapped line holding a single word. Invalidate wins over
   a fill in the same cycle */
module icache_line #(
  parameter fencei_pkg::line_idx_t LINE_IDX = '0
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   inv_i,
  input  logic                   fill_i,
  input  fencei_pkg::line_tag_t  fill_tag_i,
  input  rv_isa_pkg::insn_t      fill_insn_i,
  input  fencei_pkg::fetch_req_t fetch_i,
  output logic                   hit_o,
  output rv_isa_pkg::insn_t      insn_o
);
  import rv_isa_pkg::*;
  import fencei_pkg::*;

  logic      valid_q;
  line_tag_t tag_q;
  insn_t     insn_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (inv_i) begin
      valid_q <= 1'b0;
    end else if (fill_i) begin
      valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_i && !inv_i) begin
      tag_q  <= fill_tag_i;
      insn_q <= fill_insn_i;
    end
  end

  assign hit_o = valid_q && (tag_q == fetch_i.addr[31:INDEX_W+2])
              && (fetch_i.addr[INDEX_W+1:2] == LINE_IDX);
  assign insn_o = insn_q;

endmodule

/* rtl/icache_lookup.sv */
/* Response follows the fetch by one cycle. At most one line hits,
   a miss returns a zero word */
module icache_lookup (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  fencei_pkg::fetch_req_t           fetch_i,
  input  logic [fencei_pkg::NUM_LINES-1:0] hit_i,
  input  rv_isa_pkg::insn_t                insn_i [fencei_pkg::NUM_LINES],
  output fencei_pkg::fetch_rsp_t           fetch_rsp_o
);
  import rv_isa_pkg::*;
  import fencei_pkg::*;

  insn_t sel_insn;
  logic  rsp_valid_q;
  logic  rsp_hit_q;
  insn_t rsp_insn_q;

  // or-reduce the hitting word
  always_comb begin
    sel_insn = '0;
    for (int i = 0; i < NUM_LINES; i++) begin
      if (hit_i[i]) begin
        sel_insn = sel_insn | insn_i[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= fetch_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    rsp_hit_q  <= |hit_i;
    rsp_insn_q <= sel_insn;
  end

  assign fetch_rsp_o = '{valid: rsp_valid_q, hit: rsp_hit_q, insn: rsp_insn_q};

endmodule

/* rtl/fencei_top.sv */
/* Environment must send no retire or store strobes while busy_o is high.
   Data bus accepts every write in its issue cycle */
module fencei_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  fencei_pkg::retire_t    retire_i,
  input  fencei_pkg::store_t     store_i,
  input  logic                   data_rvalid_i,
  input  fencei_pkg::fetch_req_t fetch_i,
  input  fencei_pkg::refill_t    refill_i,
  output logic                   busy_o,
  output fencei_pkg::bus_req_t   data_req_o,
  output fencei_pkg::redirect_t  redirect_o,
  output fencei_pkg::fetch_rsp_t fetch_rsp_o
);
  import rv_isa_pkg::*;
  import fencei_pkg::*;

  logic                 drain_req;
  logic                 drained;
  logic                 flush_req;
  logic                 flush_ack;
  logic [NUM_LINES-1:0] inv;
  logic [NUM_LINES-1:0] fill;
  line_tag_t            fill_tag;
  insn_t                fill_insn;
  logic [NUM_LINES-1:0] line_hit;
  insn_t                line_insn [NUM_LINES];

  fencei_ctrl u_ctrl (
    .clk_i, .rst_ni, .retire_i,
    .drained_i(drained), .flush_ack_i(flush_ack),
    .drain_req_o(drain_req), .flush_req_o(flush_req), .busy_o, .redirect_o
  );

  lsu_write_buffer u_wbuf (
    .clk_i, .rst_ni, .store_i, .drain_req_i(drain_req), .data_rvalid_i,
    .data_req_o, .drained_o(drained)
  );

  icache_flush_seq u_seq (
    .clk_i, .rst_ni, .flush_req_i(flush_req), .refill_i,
    .inv_o(inv), .fill_o(fill), .fill_tag_o(fill_tag), .fill_insn_o(fill_insn),
    .flush_ack_o(flush_ack)
  );

  for (genvar i = 0; i < NUM_LINES; i++) begin : gen_lines
    icache_line #(.LINE_IDX(line_idx_t'(i))) u_line (
      .clk_i, .rst_ni, .inv_i(inv[i]), .fill_i(fill[i]),
      .fill_tag_i(fill_tag), .fill_insn_i(fill_insn), .fetch_i,
      .hit_o(line_hit[i]), .insn_o(line_insn[i])
    );
  end

  icache_lookup u_lookup (
    .clk_i, .rst_ni, .fetch_i, .hit_i(line_hit), .insn_i(line_insn), .fetch_rsp_o
  );

endmodule

/* sim/fencei_chk.sv */
/* Bound into fencei_ctrl. Covers the flush request/ack handshake,
   the drain rule and the redirect timing */
module fencei_chk (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  drained_i,
  input logic                  flush_req_i,
  input logic                  flush_ack_i,
  input fencei_pkg::redirect_t redirect_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;

  // request held until the ack
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_req_i && !flush_ack_i |=> flush_req_i)
    else begin
      $error("flush request dropped before its acknowledge");
      fail_cnt++;
    end

  // and dropped right after it
  a_req_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_req_i && flush_ack_i |=> !flush_req_i)
    else begin
      $error("flush request still high after its acknowledge");
      fail_cnt++;
    end

  a_req_drained: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_req_i |-> drained_i)
    else begin
      $error("flush request high while data side not drained");
      fail_cnt++;
    end

  // redirect only in the cycle after the ack
  a_redirect_slot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    redirect_i.valid |-> $past(flush_ack_i))
    else begin
      $error("redirect issued without a preceding acknowledge");
      fail_cnt++;
    end

  a_ack_redirect: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_ack_i |=> redirect_i.valid)
    else begin
      $error("acknowledge not followed by a redirect");
      fail_cnt++;
    end

endmodule

bind fencei_ctrl fencei_chk u_chk (
  .clk_i, .rst_ni, .drained_i,
  .flush_req_i(flush_req_o), .flush_ack_i, .redirect_i(redirect_o)
);

/* sim/tb_fencei_top.sv */
/* Stores, retires, refills and fetches are driven 1 ns after the clock edge.
   Stores and retires are only sent while busy_o is low */
module tb_fencei_top;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_isa_pkg::*;
  import fencei_pkg::*;

  // six tests of well under 250 cycles each
  localparam int unsigned MAX_CYCLES = 6 * 250;

  logic       clk;
  logic       rst_n;
  retire_t    retire;
  store_t     store;
  logic       data_rvalid;
  fetch_req_t fetch;
  refill_t    refill;
  logic       busy;
  bus_req_t   data_req;
  redirect_t  redirect;
  fetch_rsp_t fetch_rsp;

  integer      seed = 30;
  int unsigned cyc = 0;
  int unsigned last_due = 0;
  int unsigned n_checks = 0;
  int unsigned n_errors = 0;
  int unsigned n_redirects = 0;
  addr_t       exp_pc;
  bus_req_t    exp_bus_q [$];
  fetch_rsp_t  exp_rsp_q [$];
  int unsigned rsp_due_q [$];
  addr_t       filled_q [$];
  logic        m_valid [NUM_LINES];
  line_tag_t   m_tag [NUM_LINES];
  insn_t       m_insn [NUM_LINES];

  fencei_top uut (
    .clk_i(clk), .rst_ni(rst_n), .retire_i(retire), .store_i(store),
    .data_rvalid_i(data_rvalid), .fetch_i(fetch), .refill_i(refill),
    .busy_o(busy), .data_req_o(data_req), .redirect_o(redirect), .fetch_rsp_o(fetch_rsp)
  );

  // fetch target after fence.i
  function automatic addr_t next_pc(addr_t pc);
    return (pc & ~32'h3) + 32'd4;
  endfunction

  function automatic fetch_rsp_t exp_fetch(addr_t addr);
    fetch_rsp_t rsp;
    line_idx_t  idx;
    idx       = addr[4:2];
    rsp.valid = 1'b1;
    rsp.hit   = m_valid[idx] && (m_tag[idx] == addr[31:5]);
    rsp.insn  = rsp.hit ? m_insn[idx] : '0;
    return rsp;
  endfunction

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  function automatic addr_t rand_addr(line_idx_t idx);
    word_t w;
    w = rand_word();
    return {w[31:5], idx, 2'b00};
  endfunction

  task automatic check_rsp(fetch_rsp_t got, fetch_rsp_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %0t fetch_rsp_o got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_bus(bus_req_t got, bus_req_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %0t data_req_o got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_redirect(redirect_t got, redirect_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %0t redirect_o got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_busy(logic got, logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %0t busy_o got %b expected %b", $time, got, exp);
    end
  endtask

  task automatic note_error(string msg);
    n_errors++;
    $display("ERROR %0t %s", $time, msg);
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic refill_line(addr_t addr, insn_t insn);
    refill = '{valid: 1'b1, addr: addr, insn: insn};
    m_valid[addr[4:2]] = 1'b1;
    m_tag[addr[4:2]]   = addr[31:5];
    m_insn[addr[4:2]]  = insn;
    step();
    refill = '0;
  endtask

  task automatic issue_fetch(addr_t addr);
    fetch = '{valid: 1'b1, addr: addr};
    exp_rsp_q.push_back(exp_fetch(addr));
    step();
    fetch = '0;
  endtask

  task automatic drive_store(addr_t addr, word_t data, logic bufferable);
    store = '{valid: 1'b1, addr: addr, data: data, bufferable: bufferable};
    exp_bus_q.push_back(bus_req_t'{valid: 1'b1, addr: addr, data: data});
    step();
    store = '0;
  endtask

  // kind selects a non-fence (0), a plain fence (1) or a fence.i (2)
  task automatic retire_insn(addr_t pc, insn_t insn, int unsigned kind);
    int unsigned redirects_before;
    int unsigned waited;
    redirects_before = n_redirects;
    waited = 0;
    if (kind == 2) begin
      exp_pc = next_pc(pc);
    end
    retire = '{valid: 1'b1, pc: pc, insn: insn};
    step();
    retire = '0;
    @(negedge clk);
    check_busy(busy, kind != 0);
    while (busy && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (busy) begin
      note_error("busy_o stuck high after the retire");
    end
    if (kind != 0 && exp_bus_q.size() != 0) begin
      note_error("fence finished with stores not yet written");
    end
    if (n_redirects - redirects_before != (kind == 2 ? 1 : 0)) begin
      note_error("wrong number of redirects for the retired instruction");
    end
    step();
  endtask

  task automatic wait_idle();
    int unsigned waited;
    waited = 0;
    while (exp_bus_q.size() + exp_rsp_q.size() + rsp_due_q.size() != 0 && waited < 50) begin
      step();
      waited++;
    end
    if (waited >= 50) begin
      note_error("bus writes or fetch responses never completed");
    end
  endtask

  task automatic end_test(int unsigned num, string name, int unsigned errs_before);
    $display("test %0d %s: %0d errors", num, name, n_errors - errs_before);
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run limit
  initial begin
    while (cyc < MAX_CYCLES) begin
      @(posedge clk);
      cyc = cyc + 1;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // bus responder gives one response per cycle in issue order
  initial begin
    data_rvalid = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      data_rvalid = 1'b0;
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
        data_rvalid = 1'b1;
        void'(rsp_due_q.pop_front());
      end
    end
  end

  // compare process
  initial begin
    int unsigned due;
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (data_req.valid) begin
          if (exp_bus_q.size() == 0) begin
            note_error("bus write issued with no store pending");
          end else begin
            check_bus(data_req, exp_bus_q.pop_front());
          end
          due = cyc + 1 + ($unsigned($random(seed)) % 4);
          if (due <= last_due) begin
            due = last_due + 1;
          end
          last_due = due;
          rsp_due_q.push_back(due);
        end
        if (fetch_rsp.valid) begin
          if (exp_rsp_q.size() == 0) begin
            note_error("fetch response with no fetch pending");
          end else begin
            check_rsp(fetch_rsp, exp_rsp_q.pop_front());
          end
        end
        if (redirect.valid) begin
          if (rsp_due_q.size() != 0 || exp_bus_q.size() != 0) begin
            note_error("redirect before every write had its response");
          end
          check_redirect(redirect, redirect_t'{valid: 1'b1, pc: exp_pc});
          check_busy(busy, 1'b1);
          n_redirects++;
          for (int i = 0; i < NUM_LINES; i++) begin
            m_valid[i] = 1'b0;
          end
        end
      end
    end
  end

  initial begin
    int unsigned errs;
    word_t       w;
    addr_t       a;
    rst_n  = 1'b0;
    retire = '0;
    store  = '0;
    fetch  = '0;
    refill = '0;
    for (int i = 0; i < NUM_LINES; i++) begin
      m_valid[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step();

    errs = n_errors;
    for (int i = 0; i < 6; i++) begin
      a = rand_addr(line_idx_t'(i));
      refill_line(a, rand_word());
      filled_q.push_back(a);
    end
    foreach (filled_q[i]) begin
      issue_fetch(filled_q[i]);
    end
    // same index with another tag
    issue_fetch(filled_q[0] ^ 32'h0000_0100);
    wait_idle();
    end_test(1, "refill and lookup", errs);

    errs = n_errors;
    for (int i = 0; i < 10; i++) begin
      w = rand_word();
      drive_store(rand_addr(w[4:2]), rand_word(), w[0]);
      if (w[1]) begin
        step();
      end
    end
    // a non-bufferable store pushes out the last buffered entry
    drive_store(rand_addr(3'd5), rand_word(), 1'b0);
    wait_idle();
    end_test(2, "store order", errs);

    errs = n_errors;
    for (int r = 0; r < 2; r++) begin
      for (int i = 0; i < 3; i++) begin
        w = rand_word();
        drive_store(rand_addr(w[4:2]), rand_word(), w[0]);
      end
      retire_insn(rand_word(), FENCEI_IDATA, 2);
    end
    wait_idle();
    end_test(3, "fence.i drain and redirect", errs);

    errs = n_errors;
    foreach (filled_q[i]) begin
      issue_fetch(filled_q[i]);
    end
    foreach (filled_q[i]) begin
      refill_line(filled_q[i], rand_word());
    end
    foreach (filled_q[i]) begin
      issue_fetch(filled_q[i]);
    end
    wait_idle();
    end_test(4, "lookup after flush", errs);

    errs = n_errors;
    drive_store(rand_addr(3'd2), rand_word(), 1'b1);
    retire_insn(rand_word(), 32'h0ff0_000f, 1);
    foreach (filled_q[i]) begin
      issue_fetch(filled_q[i]);
    end
    retire_insn(rand_word(), 32'h0010_0093, 0);
    wait_idle();
    end_test(5, "plain fence and non-fence", errs);

    errs = n_errors;
    for (int r = 0; r < 4; r++) begin
      a = rand_addr(line_idx_t'(r));
      refill_line(a, rand_word());
      drive_store(rand_addr(3'd7), rand_word(), 1'b1);
      w = rand_word();
      retire_insn(rand_word(), {w[31:15], 3'b001, w[11:7], 7'b0001111}, 2);
      issue_fetch(a);
    end
    wait_idle();
    end_test(6, "fence.i field variants", errs);

    $display("checks %0d, errors %0d, assertion failures %0d",
             n_checks, n_errors, uut.u_ctrl.u_chk.fail_cnt);
    if (n_errors == 0 && uut.u_ctrl.u_chk.fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog.f */
rtl/rv_isa_pkg.sv
rtl/fencei_pkg.sv
rtl/fencei_ctrl.sv
rtl/lsu_write_buffer.sv
rtl/icache_flush_seq.sv
rtl/icache_line.sv
rtl/icache_lookup.sv
rtl/fencei_top.sv
sim/fencei_chk.sv
sim/tb_fencei_top.sv

/* Makefile */
SIM       := verilator
TOP       := tb_fencei_top
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM_FLAGS := --binary --timing --assert --timescale 1ns/1ps -j 0 --top-module $(TOP)
RUN_ARGS  := +verilator+error+limit+100
LOG       := sim.log

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
